//--- common/tcdm_consts.svh
`ifndef TCDM_CONSTS_SVH
`define TCDM_CONSTS_SVH

// Number of virtual request channels coming from the streamers.
`define TCDM_NB_IN 4

// Number of physical memory ports behind the multiplexer.
// The channel count must be a multiple of this value.
`define TCDM_NB_OUT 2

// Word address width. One address selects a full data word.
`define TCDM_AW 10

// Data word width in bits.
// The byte-enable width follows from it, one bit per byte.
`define TCDM_DW 32

// Width of the tag that the memory echoes back with the response.
`define TCDM_UW 4

// Scratchpad depth in words, matching the full word-address range.
`define TCDM_MEM_WORDS 1024

`endif

//--- common/tcdm_pkg.sv
`include "tcdm_consts.svh"

// Shared types of the TCDM subsystem.
// All widths come from the constants header, so that the package and
// the RTL always agree on the channel layout.
package tcdm_pkg;

  // Word address of a request.
  // The scratchpad is word addressed, so no byte offset is carried.
  typedef logic [`TCDM_AW-1:0] tcdm_addr_t;

  // One data word, used both for write data and for read responses.
  typedef logic [`TCDM_DW-1:0] tcdm_data_t;

  // Byte enables of a write.
  // Bit b qualifies bits 8*b+7 down to 8*b of the data word.
  typedef logic [`TCDM_DW/8-1:0] tcdm_be_t;

  // Request tag.
  // The memory returns it unchanged with the response, so an initiator
  // can match responses to its own outstanding requests.
  typedef logic [`TCDM_UW-1:0] tcdm_user_t;

endpackage

//--- hw/core_mux/tcdm_core_mux.sv
`timescale 1ns/100ps

`include "tcdm_consts.svh"

// Funnels NB_IN_CHAN request channels onto NB_OUT_CHAN memory ports.
// Channel j always uses port j modulo NB_OUT_CHAN, so each port serves a
// fixed group of NB_IN_CHAN/NB_OUT_CHAN channels.
// NB_IN_CHAN must be a multiple of NB_OUT_CHAN.
// Member m of the group on port i is input channel m*NB_OUT_CHAN+i.
// All groups share one round-robin counter that gives the member index
// where the priority scan starts.
module tcdm_core_mux import tcdm_pkg::*; #(
  parameter int unsigned NB_IN_CHAN  = `TCDM_NB_IN,
  parameter int unsigned NB_OUT_CHAN = `TCDM_NB_OUT
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,

  input  logic       [NB_IN_CHAN-1:0]  in_req,
  input  tcdm_addr_t [NB_IN_CHAN-1:0]  in_add,
  input  logic       [NB_IN_CHAN-1:0]  in_wen,
  input  tcdm_be_t   [NB_IN_CHAN-1:0]  in_be,
  input  tcdm_data_t [NB_IN_CHAN-1:0]  in_data,
  input  tcdm_user_t [NB_IN_CHAN-1:0]  in_user,
  output logic       [NB_IN_CHAN-1:0]  in_gnt,
  output logic       [NB_IN_CHAN-1:0]  in_r_valid,
  output tcdm_data_t [NB_IN_CHAN-1:0]  in_r_data,
  output tcdm_user_t [NB_IN_CHAN-1:0]  in_r_user,

  output logic       [NB_OUT_CHAN-1:0] out_req,
  output tcdm_addr_t [NB_OUT_CHAN-1:0] out_add,
  output logic       [NB_OUT_CHAN-1:0] out_wen,
  output tcdm_be_t   [NB_OUT_CHAN-1:0] out_be,
  output tcdm_data_t [NB_OUT_CHAN-1:0] out_data,
  output tcdm_user_t [NB_OUT_CHAN-1:0] out_user,
  input  logic       [NB_OUT_CHAN-1:0] out_gnt,
  input  logic       [NB_OUT_CHAN-1:0] out_r_valid,
  input  tcdm_data_t [NB_OUT_CHAN-1:0] out_r_data,
  input  tcdm_user_t [NB_OUT_CHAN-1:0] out_r_user
);

  // Number of channels sharing one port.
  localparam int unsigned GROUP = NB_IN_CHAN / NB_OUT_CHAN;

  // Width of a member index, at least one bit even for a single member.
  localparam int unsigned CW = (GROUP > 1) ? $clog2(GROUP) : 1;

  logic [CW-1:0]                  rr_counter;
  logic [NB_OUT_CHAN-1:0][CW-1:0] winner_d;
  logic [NB_OUT_CHAN-1:0][CW-1:0] winner_q;
  logic [NB_OUT_CHAN-1:0]         xfer;
  logic [NB_OUT_CHAN-1:0]         xfer_q;

  // A port transfers when its request is granted in the same cycle.
  assign xfer = out_req & out_gnt;

  // The counter moves on only when at least one port transfers.
  // A stalled cycle therefore leaves the priority order unchanged.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_counter <= '0;
    end else if (clear_i) begin
      rr_counter <= '0;
    end else if (|xfer) begin
      if (rr_counter == CW'(GROUP - 1)) begin
        rr_counter <= '0;
      end else begin
        rr_counter <= rr_counter + 1'b1;
      end
    end
  end

  // Rotating priority scan.
  // For each port, the members are visited from the counter value upwards
  // with wrap-around, and the first one that requests wins.
  // With no request in the group the winner falls back to the counter,
  // which is harmless since the port request is then low.
  always_comb begin
    int  member;
    logic found;
    for (int i = 0; i < NB_OUT_CHAN; i++) begin
      winner_d[i] = rr_counter;
      found       = 1'b0;
      for (int k = 0; k < GROUP; k++) begin
        member = int'(rr_counter) + k;
        if (member >= GROUP) begin
          member = member - GROUP;
        end
        if (!found && in_req[member*NB_OUT_CHAN+i]) begin
          winner_d[i] = CW'(member);
          found       = 1'b1;
        end
      end
    end
  end

  // Request path.
  // The port requests whenever any member of its group requests, and it
  // carries the fields of the current winner.
  always_comb begin
    int sel;
    for (int i = 0; i < NB_OUT_CHAN; i++) begin
      sel        = int'(winner_d[i]) * NB_OUT_CHAN + i;
      out_req[i] = 1'b0;
      for (int k = 0; k < GROUP; k++) begin
        out_req[i] = out_req[i] | in_req[k*NB_OUT_CHAN+i];
      end
      out_add[i]  = in_add[sel];
      out_wen[i]  = in_wen[sel];
      out_be[i]   = in_be[sel];
      out_data[i] = in_data[sel];
      out_user[i] = in_user[sel];
    end
  end

  // The winner and the transfer flag are kept for one cycle.
  // The memory answers exactly one cycle after the transfer, so this is
  // all the state needed to route the response back.
  // A clear drops the flag, which squashes the pending response.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      winner_q <= '0;
      xfer_q   <= '0;
    end else if (clear_i) begin
      winner_q <= '0;
      xfer_q   <= '0;
    end else begin
      winner_q <= winner_d;
      xfer_q   <= xfer;
    end
  end

  // Grant and response steering.
  // The grant goes back to the current winner only, within the same cycle.
  // The response goes to the winner registered in the previous cycle.
  // All other members of the group see zeros.
  always_comb begin
    int sel_d;
    int sel_q;
    in_gnt     = '0;
    in_r_valid = '0;
    in_r_data  = '0;
    in_r_user  = '0;
    for (int i = 0; i < NB_OUT_CHAN; i++) begin
      sel_d = int'(winner_d[i]) * NB_OUT_CHAN + i;
      sel_q = int'(winner_q[i]) * NB_OUT_CHAN + i;
      in_gnt[sel_d]     = out_gnt[i];
      in_r_valid[sel_q] = out_r_valid[i] & xfer_q[i];
      in_r_data[sel_q]  = out_r_data[i];
      in_r_user[sel_q]  = out_r_user[i];
    end
  end

endmodule

//--- hw/tcdm_scratchpad.sv
`timescale 1ns/100ps

`include "tcdm_consts.svh"

// Multi-ported word memory with byte enables.
// Every port accepts a request in the cycle it arrives unless its stall
// bit is set, and answers with a registered response one cycle later.
// All ports share a single storage array.
module tcdm_scratchpad import tcdm_pkg::*; #(
  parameter int unsigned NB_PORTS = `TCDM_NB_OUT
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic       [NB_PORTS-1:0] stall,

  input  logic       [NB_PORTS-1:0] req,
  input  tcdm_addr_t [NB_PORTS-1:0] add,
  input  logic       [NB_PORTS-1:0] wen,
  input  tcdm_be_t   [NB_PORTS-1:0] be,
  input  tcdm_data_t [NB_PORTS-1:0] data,
  input  tcdm_user_t [NB_PORTS-1:0] user,
  output logic       [NB_PORTS-1:0] gnt,
  output logic       [NB_PORTS-1:0] r_valid,
  output tcdm_data_t [NB_PORTS-1:0] r_data,
  output tcdm_user_t [NB_PORTS-1:0] r_user
);

  // Number of byte lanes in a word.
  localparam int unsigned NB_BYTES = $bits(tcdm_be_t);

  tcdm_data_t              mem [`TCDM_MEM_WORDS];
  logic     [NB_PORTS-1:0] xfer;

  // The stall bit stands for another master holding the port.
  // Without it, every request is accepted at once.
  assign gnt  = req & ~stall;
  assign xfer = req & gnt;

  // Byte-enabled writes.
  // Ports are visited from the highest index down, so when two ports write
  // the same byte the lowest port's update is the last one and wins.
  always_ff @(posedge clk_i) begin
    for (int p = NB_PORTS - 1; p >= 0; p--) begin
      if (xfer[p] && !wen[p]) begin
        for (int b = 0; b < NB_BYTES; b++) begin
          if (be[p][b]) begin
            mem[add[p]][8*b+:8] <= data[p][8*b+:8];
          end
        end
      end
    end
  end

  // Response payload.
  // The array is sampled before the writes of the same edge take effect,
  // so a read sees the word as it was before any write in its cycle.
  // Write transfers return the old word too, which the initiator ignores.
  always_ff @(posedge clk_i) begin
    for (int p = 0; p < NB_PORTS; p++) begin
      if (xfer[p]) begin
        r_data[p] <= mem[add[p]];
        r_user[p] <= user[p];
      end
    end
  end

  // One valid pulse per transfer, both for reads and for writes.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid <= '0;
    end else begin
      r_valid <= xfer;
    end
  end

endmodule

//--- hw/tcdm_subsystem_top.sv
`timescale 1ns/100ps

`include "tcdm_consts.svh"

// TCDM subsystem.
// The streamer channels enter the round-robin multiplexer, which feeds
// the ports of the scratchpad.
// The stall inputs let the environment model other masters on the ports.
module tcdm_subsystem_top import tcdm_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  input  logic       [`TCDM_NB_OUT-1:0]  bank_stall,

  input  logic       [`TCDM_NB_IN-1:0]   in_req,
  input  tcdm_addr_t [`TCDM_NB_IN-1:0]   in_add,
  input  logic       [`TCDM_NB_IN-1:0]   in_wen,
  input  tcdm_be_t   [`TCDM_NB_IN-1:0]   in_be,
  input  tcdm_data_t [`TCDM_NB_IN-1:0]   in_data,
  input  tcdm_user_t [`TCDM_NB_IN-1:0]   in_user,
  output logic       [`TCDM_NB_IN-1:0]   in_gnt,
  output logic       [`TCDM_NB_IN-1:0]   in_r_valid,
  output tcdm_data_t [`TCDM_NB_IN-1:0]   in_r_data,
  output tcdm_user_t [`TCDM_NB_IN-1:0]   in_r_user
);

  // Memory-port side of the multiplexer.
  logic       [`TCDM_NB_OUT-1:0] port_req;
  tcdm_addr_t [`TCDM_NB_OUT-1:0] port_add;
  logic       [`TCDM_NB_OUT-1:0] port_wen;
  tcdm_be_t   [`TCDM_NB_OUT-1:0] port_be;
  tcdm_data_t [`TCDM_NB_OUT-1:0] port_data;
  tcdm_user_t [`TCDM_NB_OUT-1:0] port_user;
  logic       [`TCDM_NB_OUT-1:0] port_gnt;
  logic       [`TCDM_NB_OUT-1:0] port_r_valid;
  tcdm_data_t [`TCDM_NB_OUT-1:0] port_r_data;
  tcdm_user_t [`TCDM_NB_OUT-1:0] port_r_user;

  tcdm_core_mux #(
    .NB_IN_CHAN  (`TCDM_NB_IN),
    .NB_OUT_CHAN (`TCDM_NB_OUT)
  ) u_core_mux (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .in_req      (in_req),
    .in_add      (in_add),
    .in_wen      (in_wen),
    .in_be       (in_be),
    .in_data     (in_data),
    .in_user     (in_user),
    .in_gnt      (in_gnt),
    .in_r_valid  (in_r_valid),
    .in_r_data   (in_r_data),
    .in_r_user   (in_r_user),
    .out_req     (port_req),
    .out_add     (port_add),
    .out_wen     (port_wen),
    .out_be      (port_be),
    .out_data    (port_data),
    .out_user    (port_user),
    .out_gnt     (port_gnt),
    .out_r_valid (port_r_valid),
    .out_r_data  (port_r_data),
    .out_r_user  (port_r_user)
  );

  // One scratchpad port per multiplexer output.
  tcdm_scratchpad #(
    .NB_PORTS (`TCDM_NB_OUT)
  ) u_scratchpad (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .stall   (bank_stall),
    .req     (port_req),
    .add     (port_add),
    .wen     (port_wen),
    .be      (port_be),
    .data    (port_data),
    .user    (port_user),
    .gnt     (port_gnt),
    .r_valid (port_r_valid),
    .r_data  (port_r_data),
    .r_user  (port_r_user)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the TCDM testbench with Verilator and runs it.
# The run passes only if the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tcdm_tb \
  --Mdir obj_dir -o tcdm_sim &&
  ./obj_dir/tcdm_sim +verilator+error+limit+1000 > "$LOG" 2>&1 ||
  { cat "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"

grep -q "Verification passed" "$LOG" && exit 0 || exit 1

//--- sources.f
+incdir+common
common/tcdm_pkg.sv
hw/core_mux/tcdm_core_mux.sv
hw/tcdm_scratchpad.sv
hw/tcdm_subsystem_top.sv
tb/tcdm_checker.sv
tb/tcdm_tb.sv

//--- tb/tcdm_checker.sv
`timescale 1ns/100ps

`include "tcdm_consts.svh"

// Protocol and fairness assertions for the TCDM subsystem.
// The module is bound into the subsystem top and only observes the
// channel side of the multiplexer together with the port stalls.
// Member m of the group on port i is channel m*NB_OUT+i.
module tcdm_checker import tcdm_pkg::*; (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           clear_i,
  input logic       [`TCDM_NB_OUT-1:0]  bank_stall,
  input logic       [`TCDM_NB_IN-1:0]   in_req,
  input tcdm_user_t [`TCDM_NB_IN-1:0]   in_user,
  input logic       [`TCDM_NB_IN-1:0]   in_gnt,
  input logic       [`TCDM_NB_IN-1:0]   in_r_valid,
  input tcdm_user_t [`TCDM_NB_IN-1:0]   in_r_user
);

  localparam int NI = `TCDM_NB_IN;
  localparam int NO = `TCDM_NB_OUT;
  localparam int G  = NI / NO;

  // Number of failed assertions, read by the testbench at the end.
  int unsigned assert_fails = 0;

  logic                seen_req;
  logic [NI-1:0][7:0]  starve;
  logic                all_busy;

  // Every channel requests and no port is held by another master.
  // In such a cycle every port transfers and the winner is the counter.
  assign all_busy = (&in_req) && (bank_stall == '0);

  // Set by the first request after reset.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_req <= 1'b0;
    end else if (|in_req) begin
      seen_req <= 1'b1;
    end
  end

  // Consecutive cycles a channel has waited with no port stalled.
  // A stall or a clear restarts the count.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      starve <= '0;
    end else begin
      for (int j = 0; j < NI; j++) begin
        if (in_req[j] && !in_gnt[j] && (bank_stall == '0) && !clear_i) begin
          starve[j] <= starve[j] + 8'd1;
        end else begin
          starve[j] <= '0;
        end
      end
    end
  end

  a_quiet_after_reset: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!seen_req && !(|in_req)) |-> (in_gnt == '0 && in_r_valid == '0))
  else begin
    $error("Grant or response seen before the first request");
    assert_fails++;
  end

  a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_gnt & ~in_req) == '0)
  else begin
    $error("A channel was granted without a request");
    assert_fails++;
  end

  for (genvar j = 0; j < NI; j++) begin : g_chan
    // The response follows every transfer after exactly one cycle.
    a_resp_after_xfer: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (in_req[j] && in_gnt[j] && !clear_i) |=>
        (in_r_valid[j] && in_r_user[j] == $past(in_user[j])))
    else begin
      $error("Channel %0d missed its response or got a wrong tag", j);
      assert_fails++;
    end

    a_no_stray_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      in_r_valid[j] |-> $past(in_req[j] && in_gnt[j] && !clear_i))
    else begin
      $error("Channel %0d got a response without a transfer", j);
      assert_fails++;
    end

    // With the counter moving every cycle, a waiting member is reached
    // within one turn of the group.
    a_fair_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
      starve[j] < 8'(G))
    else begin
      $error("Channel %0d waited a full round without a grant", j);
      assert_fails++;
    end
  end

  for (genvar i = 0; i < NO; i++) begin : g_port
    logic [G-1:0] grp_gnt;

    for (genvar m = 0; m < G; m++) begin : g_member
      assign grp_gnt[m] = in_gnt[m*NO+i];

      // With everybody requesting, the grant steps to the next member.
      a_rotate: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!clear_i && all_busy && $past(!clear_i && all_busy && in_gnt[m*NO+i]))
          |-> in_gnt[((m+1)%G)*NO+i])
      else begin
        $error("Port %0d did not pass the grant on from member %0d", i, m);
        assert_fails++;
      end
    end

    a_one_winner: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(grp_gnt))
    else begin
      $error("Port %0d granted more than one channel", i);
      assert_fails++;
    end

    a_stall_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
      bank_stall[i] |-> (grp_gnt == '0))
    else begin
      $error("Port %0d granted a channel while stalled", i);
      assert_fails++;
    end

    // A clear restarts the scan at member 0, which is channel i.
    a_clear_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ($past(clear_i) && !clear_i && all_busy) |-> in_gnt[i])
    else begin
      $error("Port %0d did not start at member 0 after a clear", i);
      assert_fails++;
    end
  end

endmodule

//--- tb/tcdm_tb.sv
`timescale 1ns/100ps

`include "tcdm_consts.svh"

// Testbench for the TCDM subsystem.
// Random streamer traffic runs through the DUT while a reference memory
// and per-channel queues of expected responses check every response.
// Protocol, fairness and clear behaviour are checked by the bound checker.
module tcdm_tb import tcdm_pkg::*; ();

  localparam int NI         = `TCDM_NB_IN;
  localparam int NO         = `TCDM_NB_OUT;
  localparam int G          = NI / NO;
  localparam int DW         = `TCDM_DW;
  localparam int UW         = `TCDM_UW;
  localparam int BW         = DW / 8;
  localparam int REGION     = `TCDM_MEM_WORDS / NI;
  localparam int EW         = 1 + BW + DW + UW;
  localparam int WAIT_LIMIT = 200;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  clear_i;
  logic       [NO-1:0]   bank_stall;
  logic       [NI-1:0]   in_req;
  tcdm_addr_t [NI-1:0]   in_add;
  logic       [NI-1:0]   in_wen;
  tcdm_be_t   [NI-1:0]   in_be;
  tcdm_data_t [NI-1:0]   in_data;
  tcdm_user_t [NI-1:0]   in_user;
  logic       [NI-1:0]   in_gnt;
  logic       [NI-1:0]   in_r_valid;
  tcdm_data_t [NI-1:0]   in_r_data;
  tcdm_user_t [NI-1:0]   in_r_user;

  // Traffic knobs in percent, changed between phases.
  int            req_pct;
  int            stall_pct;
  logic [31:0]   rng_state;
  int unsigned   data_errors;
  int unsigned   timeouts;

  // Reference memory, with a flag per byte that has been written.
  tcdm_data_t    ref_mem   [`TCDM_MEM_WORDS];
  tcdm_be_t      ref_known [`TCDM_MEM_WORDS];

  // Expected responses per channel, packed as {read, known, data, user}.
  logic [EW-1:0] exp_q [NI][$];

  tcdm_subsystem_top dut0 (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .bank_stall (bank_stall),
    .in_req     (in_req),
    .in_add     (in_add),
    .in_wen     (in_wen),
    .in_be      (in_be),
    .in_data    (in_data),
    .in_user    (in_user),
    .in_gnt     (in_gnt),
    .in_r_valid (in_r_valid),
    .in_r_data  (in_r_data),
    .in_r_user  (in_r_user)
  );

  bind tcdm_subsystem_top tcdm_checker u_checker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .bank_stall (bank_stall),
    .in_req     (in_req),
    .in_user    (in_user),
    .in_gnt     (in_gnt),
    .in_r_valid (in_r_valid),
    .in_r_user  (in_r_user)
  );

  always #10 clk_i = ~clk_i;

  // 32-bit xorshift step.
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Turns byte enables into a bit mask over the data word.
  function automatic tcdm_data_t byte_mask(input tcdm_be_t be);
    tcdm_data_t m;
    m = '0;
    for (int b = 0; b < BW; b++) begin
      if (be[b]) begin
        m[8*b+:8] = 8'hff;
      end
    end
    return m;
  endfunction

  // Streamer model.
  // A channel keeps its request until granted, then draws a new one.
  // Each channel stays in a 16-word window of its own region.
  always @(posedge clk_i) begin
    logic [31:0] r;
    if (rst_ni) begin
      for (int j = 0; j < NI; j++) begin
        if (!in_req[j] || in_gnt[j]) begin
          r = next_rand();
          if ((r % 100) < req_pct) begin
            in_req[j]  <= 1'b1;
            in_wen[j]  <= r[0];
            in_be[j]   <= tcdm_be_t'(r >> 4);
            in_user[j] <= tcdm_user_t'(r >> 8);
            in_add[j]  <= tcdm_addr_t'(j * REGION + ((r >> 16) % 16));
            in_data[j] <= next_rand();
          end else begin
            in_req[j] <= 1'b0;
          end
        end
      end
      for (int p = 0; p < NO; p++) begin
        bank_stall[p] <= (next_rand() % 100) < stall_pct;
      end
    end
  end

  // Response checks first, then the transfers of the cycle that ends here.
  always @(posedge clk_i) begin
    logic [EW-1:0] e;
    tcdm_data_t    m;
    tcdm_addr_t    a;
    if (rst_ni) begin
      for (int j = 0; j < NI; j++) begin
        if (in_r_valid[j]) begin
          assert (exp_q[j].size() != 0) else begin
            $display("Channel %0d gave a response at %0t with nothing outstanding",
                     j, $time);
            data_errors++;
          end
          if (exp_q[j].size() != 0) begin
            e = exp_q[j].pop_front();
            assert (in_r_user[j] === e[UW-1:0]) else begin
              $display("Mismatch at %0t: in_r_user[%0d] got %h expected %h",
                       $time, j, in_r_user[j], e[UW-1:0]);
              data_errors++;
            end
            // Only bytes written earlier have a known value.
            m = byte_mask(e[EW-2 -: BW]);
            if (e[EW-1]) begin
              assert ((in_r_data[j] & m) === (e[UW+DW-1:UW] & m)) else begin
                $display("Mismatch at %0t: in_r_data[%0d] got %h expected %h",
                         $time, j, in_r_data[j] & m, e[UW+DW-1:UW] & m);
                data_errors++;
              end
            end
          end
        end
      end
      for (int j = 0; j < NI; j++) begin
        if (in_req[j] && in_gnt[j]) begin
          a = in_add[j];
          if (in_wen[j]) begin
            e = {1'b1, ref_known[a], ref_mem[a], in_user[j]};
          end else begin
            for (int b = 0; b < BW; b++) begin
              if (in_be[j][b]) begin
                ref_mem[a][8*b+:8] = in_data[j][8*b+:8];
                ref_known[a][b]    = 1'b1;
              end
            end
            e = {1'b0, tcdm_be_t'(0), tcdm_data_t'(0), in_user[j]};
          end
          // A clear in the transfer cycle squashes the response.
          if (!clear_i) begin
            exp_q[j].push_back(e);
          end
        end
      end
    end
  end

  initial begin
    int k;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    bank_stall  = '0;
    in_req      = '0;
    in_add      = '0;
    in_wen      = '0;
    in_be       = '0;
    in_data     = '0;
    in_user     = '0;
    req_pct     = 0;
    stall_pct   = 0;
    rng_state   = 32'd31;
    data_errors = 0;
    timeouts    = 0;
    for (int w = 0; w < `TCDM_MEM_WORDS; w++) begin
      ref_mem[w]   = '0;
      ref_known[w] = '0;
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Idle cycles after reset, then random traffic with and without stalls.
    repeat (6) @(posedge clk_i);
    req_pct   <= 60;
    stall_pct <= 30;
    repeat (400) @(posedge clk_i);
    req_pct   <= 70;
    stall_pct <= 0;
    repeat (300) @(posedge clk_i);
    // Every channel requests in every cycle for the clear test.
    // The clear follows a grant to the last member of port 0, so the
    // counter would not be back at zero on its own after the clear cycle.
    req_pct <= 100;
    k = 0;
    while (!((&in_req) && (bank_stall == '0) && in_gnt[(G - 1) * NO]) &&
           k < WAIT_LIMIT) begin
      @(posedge clk_i);
      k++;
    end
    if (k >= WAIT_LIMIT) begin
      $display("Timeout: no cycle with all channels requesting and the last member granted");
      timeouts++;
    end else begin
      clear_i <= 1'b1;
      @(posedge clk_i);
      clear_i <= 1'b0;
      repeat (40) @(posedge clk_i);
      req_pct <= 0;
      k = 0;
      while (in_req != '0 && k < WAIT_LIMIT) begin
        @(posedge clk_i);
        k++;
      end
      if (k >= WAIT_LIMIT) begin
        $display("Timeout: the traffic did not drain");
        timeouts++;
      end
      repeat (3) @(posedge clk_i);
    end
    for (int j = 0; j < NI; j++) begin
      assert (exp_q[j].size() == 0) else begin
        $display("Channel %0d is still missing %0d responses", j, exp_q[j].size());
        data_errors++;
      end
    end
    $display("Error counts: data %0d, assertions %0d, timeouts %0d",
             data_errors, dut0.u_checker.assert_fails, timeouts);
    if (data_errors == 0 && dut0.u_checker.assert_fails == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
